// ==== src/requant_pkg.sv ====
`default_nettype none

package requant_pkg;

  //====================================================================
  // widths
  //====================================================================

  // requantized sample
  localparam int DWIDTH    = 16;

  // shift amount, enough to cover 0..DWIDTH-1
  localparam int DWIDTHLOG = 4;

  // accumulator product
  localparam int PWIDTH    = 2 * DWIDTH;

  // apb data word
  localparam int BWIDTH    = 32;

  // apb byte address
  localparam int AWIDTH    = 8;

  //====================================================================
  // register map
  //====================================================================

  // fraction bits for the requantizer
  localparam logic [AWIDTH-1:0] REG_QBITS = 8'h08;

  //====================================================================
  // vector types
  //====================================================================

  typedef logic signed [DWIDTH-1:0]    data_t;
  typedef logic signed [PWIDTH-1:0]    prod_t;
  typedef logic        [DWIDTHLOG-1:0] qbits_t;
  typedef logic        [BWIDTH-1:0]    word_t;
  typedef logic        [AWIDTH-1:0]    addr_t;

endpackage

`default_nettype wire

// ==== src/param_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module param_regs (
  input  logic                clk,
  input  logic                xrst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  requant_pkg::addr_t  paddr,
  input  requant_pkg::word_t  pwdata,
  output requant_pkg::word_t  prdata,
  output requant_pkg::qbits_t qbits
);

  import requant_pkg::*;

  //====================================================================
  // apb decode
  //====================================================================

  logic   access;
  logic   hit_qbits;
  logic   wr_qbits;
  logic   rd_access;
  qbits_t qbits_r;
  word_t  rdata;

  // second cycle of a transfer, no wait states
  assign access    = psel && penable;

  assign hit_qbits = (paddr == REG_QBITS);

  assign wr_qbits  = access && pwrite && hit_qbits;

  // reads of unmapped addresses fall through to zero
  assign rd_access = access && !pwrite;

  //====================================================================
  // qbits register
  //====================================================================

  // only the low bits of the word are kept
  always_ff @(posedge clk) begin
    if (!xrst) begin
      qbits_r <= '0;
    end else if (wr_qbits) begin
      qbits_r <= pwdata[DWIDTHLOG-1:0];
    end
  end

  assign qbits = qbits_r;

  //====================================================================
  // read data
  //====================================================================

  always_comb begin
    rdata = '0;
    if (rd_access && hit_qbits) begin
      rdata = word_t'(qbits_r);
    end
  end

  // valid during the access cycle only
  assign prdata = rdata;

endmodule

`default_nettype wire

// ==== src/requant_shift.sv ====
`timescale 1ns/1ns
`default_nettype none

module requant_shift (
  input  logic                clk,
  input  logic                xrst,
  input  logic                in_valid,
  input  requant_pkg::prod_t  in_data,
  input  requant_pkg::qbits_t qbits,
  output logic                shift_valid,
  output logic                shift_neg,
  output requant_pkg::prod_t  shift_data
);

  import requant_pkg::*;

  prod_t shifted;
  logic  neg;
  logic  valid_r;
  logic  neg_r;
  prod_t data_r;

  //====================================================================
  // arithmetic shift
  //====================================================================

  // sign fill from the top bit of the product
  assign shifted = in_data >>> qbits;

  // sign of the product before the shift
  assign neg = in_data[PWIDTH-1];

  //====================================================================
  // stage register
  //====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= in_valid;
    end
  end

  // qbits is sampled together with the product
  always_ff @(posedge clk) begin
    if (in_valid) begin
      data_r <= shifted;
      neg_r  <= neg;
    end
  end

  assign shift_valid = valid_r;
  assign shift_neg   = neg_r;
  assign shift_data  = data_r;

endmodule

`default_nettype wire

// ==== src/requant_round.sv ====
`timescale 1ns/1ns
`default_nettype none

module requant_round (
  input  logic               clk,
  input  logic               xrst,
  input  logic               shift_valid,
  input  logic               shift_neg,
  input  requant_pkg::prod_t shift_data,
  output logic               out_valid,
  output requant_pkg::data_t out_data
);

  import requant_pkg::*;

  data_t trunc;
  data_t rounded;
  logic  valid_r;
  data_t data_r;

  //====================================================================
  // truncate and correct
  //====================================================================

  assign trunc = shift_data[DWIDTH-1:0];

  // negative products lose one more lsb, wraps within DWIDTH
  assign rounded = shift_neg ? data_t'(trunc - data_t'(1)) : trunc;

  //====================================================================
  // output register
  //====================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= shift_valid;
    end
  end

  // holds the last sample between items
  always_ff @(posedge clk) begin
    if (shift_valid) begin
      data_r <= rounded;
    end
  end

  assign out_valid = valid_r;
  assign out_data  = data_r;

endmodule

`default_nettype wire

// ==== src/requant_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module requant_top (
  input  logic               clk,
  input  logic               xrst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  requant_pkg::addr_t paddr,
  input  requant_pkg::word_t pwdata,
  output requant_pkg::word_t prdata,
  input  logic               in_valid,
  input  requant_pkg::prod_t in_data,
  output logic               out_valid,
  output requant_pkg::data_t out_data
);

  import requant_pkg::*;

  qbits_t qbits;
  logic   shift_valid;
  logic   shift_neg;
  prod_t  shift_data;

  //====================================================================
  // parameter registers
  //====================================================================

  param_regs param_regs_i (
    .clk     (clk),
    .xrst    (xrst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .qbits   (qbits)
  );

  //====================================================================
  // two stage requantizer
  //====================================================================

  // stage 1 shift by qbits
  requant_shift requant_shift_i (
    .clk         (clk),
    .xrst        (xrst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .qbits       (qbits),
    .shift_valid (shift_valid),
    .shift_neg   (shift_neg),
    .shift_data  (shift_data)
  );

  // stage 2 truncate and sign correction
  requant_round requant_round_i (
    .clk         (clk),
    .xrst        (xrst),
    .shift_valid (shift_valid),
    .shift_neg   (shift_neg),
    .shift_data  (shift_data),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

endmodule

`default_nettype wire

// ==== tb/requant_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module requant_tb;

  import requant_pkg::*;

  logic  clk;
  logic  xrst;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  in_valid;
  prod_t in_data;
  logic  out_valid;
  data_t out_data;

  // test table
  logic [8*24-1:0] t_name [$];
  logic [7:0]      t_kind [$];
  logic [31:0]     t_a    [$];
  logic [31:0]     t_b    [$];
  int              n_tests;
  logic            loaded;

  // items in flight, appended by the driver, walked by the monitor
  logic [15:0] exp_data  [$];
  int          exp_test  [$];
  int          exp_cycle [$];
  int          wr_ptr;
  int          rd_ptr;

  int cycle_cnt;
  int pass_cnt;
  int fail_cnt;
  int mon_pass;
  int mon_fail;

  requant_top requant_top_i (
    .clk       (clk),
    .xrst      (xrst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //====================================================================
  // output monitor
  //====================================================================

  always @(negedge clk) begin
    if (xrst && out_valid) begin
      if (rd_ptr == wr_ptr) begin
        $display("output %h appeared with no item in flight", out_data);
        mon_fail++;
      end else if (out_data !== exp_data[rd_ptr]) begin
        $display("[FAIL] %0s expected %h actual %h", t_name[exp_test[rd_ptr]],
                 exp_data[rd_ptr], out_data);
        mon_fail++;
      end else if (cycle_cnt - exp_cycle[rd_ptr] != 2) begin
        $display("[FAIL] %0s latency expected 2 actual %0d", t_name[exp_test[rd_ptr]],
                 cycle_cnt - exp_cycle[rd_ptr]);
        mon_fail++;
      end else begin
        $display("[PASS] %0s", t_name[exp_test[rd_ptr]]);
        mon_pass++;
      end
      if (rd_ptr != wr_ptr) begin
        rd_ptr++;
      end
    end
  end

  // run length follows the size of the tests file
  initial begin
    wait (loaded);
    repeat (n_tests * 10 + 50) @(posedge clk);
    $display("timeout: the tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  //====================================================================
  // tasks
  //====================================================================

  task automatic load_tests(input int fd);
    string           line;
    int              code;
    logic [8*24-1:0] nm;
    logic [7:0]      kd;
    logic [31:0]     va;
    logic [31:0]     vb;
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // skip blank and comment lines
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %s %h %h", nm, kd, va, vb);
        if (code == 4) begin
          t_name.push_back(nm);
          t_kind.push_back(kd);
          t_a.push_back(va);
          t_b.push_back(vb);
        end
      end
    end
    $fclose(fd);
    n_tests = t_name.size();
    loaded = 1'b1;
  endtask

  task automatic apply_reset();
    repeat (2) @(negedge clk);
    xrst = 1'b1;
    if (out_valid !== 1'b0 || prdata !== '0) begin
      $display("outputs were not cleared by reset");
      fail_cnt++;
    end else begin
      $display("[PASS] reset_state");
      pass_cnt++;
    end
  endtask

  task automatic apb_write(input addr_t addr, input word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    // still inside the access cycle
    @(negedge clk);
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic push_item(input int idx);
    in_valid = 1'b1;
    in_data  = t_a[idx];
    exp_data.push_back(t_b[idx][15:0]);
    exp_test.push_back(idx);
    // cycle in which in_valid is presented
    exp_cycle.push_back(cycle_cnt);
    wr_ptr++;
  endtask

  task automatic run_tests();
    int    i;
    int    k;
    int    nb;
    int    fails_before;
    word_t rd;
    i = 0;
    while (i < n_tests) begin
      if (t_kind[i] == "W") begin
        apb_write(t_a[i][AWIDTH-1:0], t_b[i]);
        $display("[PASS] %0s", t_name[i]);
        pass_cnt++;
        i++;
      end else if (t_kind[i] == "R") begin
        apb_read(t_a[i][AWIDTH-1:0], rd);
        if (rd !== t_b[i]) begin
          $display("[FAIL] %0s expected %h actual %h", t_name[i], t_b[i], rd);
          fail_cnt++;
        end else begin
          $display("[PASS] %0s", t_name[i]);
          pass_cnt++;
        end
        i++;
      end else if (t_kind[i] == "D") begin
        @(negedge clk);
        push_item(i);
        @(negedge clk);
        in_valid = 1'b0;
        wait (rd_ptr == wr_ptr);
        i++;
      end else if (t_kind[i] == "B") begin
        nb = int'(t_a[i]);
        fails_before = mon_fail;
        // one item per cycle, no gaps
        for (k = 1; k <= nb; k++) begin
          @(negedge clk);
          push_item(i + k);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (rd_ptr == wr_ptr);
        if (mon_fail != fails_before) begin
          $display("burst %0s had %0d bad items", t_name[i], mon_fail - fails_before);
          fail_cnt++;
        end else begin
          $display("[PASS] %0s", t_name[i]);
          pass_cnt++;
        end
        i = i + nb + 1;
      end else begin
        $display("test %0s has an unknown kind", t_name[i]);
        fail_cnt++;
        i++;
      end
    end
  endtask

  //====================================================================
  // main sequence
  //====================================================================

  initial begin
    int fd;
    xrst     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    in_valid = 1'b0;
    in_data  = '0;
    loaded   = 1'b0;
    fd = $fopen("tb/requant_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the tests file tb/requant_tests.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      load_tests(fd);
      apply_reset();
      run_tests();
      // catch stray outputs after the last item
      repeat (4) @(negedge clk);
      $display("passed %0d failed %0d", pass_cnt + mon_pass, fail_cnt + mon_fail);
      if (fail_cnt + mon_fail == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== requant.f ====
src/requant_pkg.sv
src/param_regs.sv
src/requant_shift.sv
src/requant_round.sv
src/requant_top.sv
tb/requant_tb.sv

// ==== Makefile ====
TOP := requant_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --top-module $(TOP) -f requant.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/requant_tests.txt ====
# columns: name kind a b
# W: a = apb address, b = write data    R: a = apb address, b = expected prdata
# D: a = product, b = expected out_data B: a = count of D lines that follow, b unused
rd_qbits_reset   R 08 00000000
pos_q0           D 00001234 1234
neg_q0           D ffff8000 7fff
trunc_q0         D 00123456 3456
minus1_q0        D ffffffff fffe
zero_q0          D 00000000 0000
wr_qbits_4       W 08 00000004
rd_qbits_4       R 08 00000004
wr_other         W 0c 0000000f
rd_qbits_kept    R 08 00000004
rd_other         R 0c 00000000
rd_unmapped      R 00 00000000
pos_q4           D 00012345 1234
neg_q4           D fffedcba edca
max_q4           D 7fffffff ffff
min_q4           D 80000000 ffff
wr_qbits_wide    W 08 fffffff3
rd_qbits_3       R 08 00000003
pos_q3           D 00001000 0200
neg_q3           D fffff000 fdff
wr_qbits_8       W 08 00000008
pos_q8           D 12345678 3456
neg_q8           D 87654321 6542
small_neg_q8     D ffffff00 fffe
wr_qbits_15      W 08 0000000f
rd_qbits_15      R 08 0000000f
pos_q15          D 40000000 8000
neg_q15          D c0000000 7fff
under_q15        D 00007fff 0000
small_neg_q15    D ffff8001 fffe
wr_qbits_2       W 08 00000002
burst_q2         B 5 0
burst_0          D 00000400 0100
burst_1          D fffffc00 feff
burst_2          D 00040008 0002
burst_3          D 80000003 ffff
burst_4          D 0001fffc 7fff
wr_qbits_1       W 08 00000001
before_switch    D 00000010 0008
wr_qbits_3b      W 08 00000003
after_switch     D 00000010 0002
after_switch_neg D fffffff0 fffd
